// ==== hw/rv_decode_pkg.sv ====
// Decoder field types, opcode and operation-code constants, format enum, decode record
`default_nettype none

package rv_decode_pkg;

    typedef logic [31:0]        instr_t;
    typedef logic [6:0]         opcode_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic signed [63:0] imm_t;
    typedef logic [5:0]         shamt_t;
    typedef logic [7:0]         op_code_t;

    // Major opcodes, instruction bits 6:0
    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;
    localparam opcode_t OPC_JAL       = 7'b1101111;
    localparam opcode_t OPC_JALR      = 7'b1100111;
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_SYSTEM    = 7'b1110011;
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_OP_32     = 7'b0111011; // W register ops
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011; // IW immediate ops

    // Base R-type
    localparam op_code_t OP_ADD  = 8'd0,  OP_SUB = 8'd1, OP_XOR = 8'd2, OP_OR = 8'd3;
    localparam op_code_t OP_AND  = 8'd4,  OP_SLL = 8'd5, OP_SRL = 8'd6, OP_SRA = 8'd7;
    localparam op_code_t OP_SLT  = 8'd8,  OP_SLTU = 8'd9;

    // M extension
    localparam op_code_t OP_MUL  = 8'd10, OP_MULH = 8'd11, OP_MULHSU = 8'd12, OP_MULHU = 8'd13;
    localparam op_code_t OP_DIV  = 8'd14, OP_DIVU = 8'd15, OP_REM = 8'd16, OP_REMU = 8'd17;

    // I-type ALU and shifts
    localparam op_code_t OP_ADDI = 8'd18, OP_XORI = 8'd19, OP_ORI = 8'd20, OP_ANDI = 8'd21;
    localparam op_code_t OP_SLLI = 8'd22, OP_SRLI = 8'd23, OP_SRAI = 8'd24;
    localparam op_code_t OP_SLTI = 8'd25, OP_SLTIU = 8'd26;

    // 27 and 28 are unassigned
    localparam op_code_t OP_ADDIW = 8'd29, OP_SLLIW = 8'd30, OP_SRLIW = 8'd31, OP_SRAIW = 8'd32;
    localparam op_code_t OP_ADDW = 8'd33, OP_SUBW = 8'd34, OP_SLLW = 8'd35, OP_SRLW = 8'd36;
    localparam op_code_t OP_SRAW = 8'd37, OP_MULW = 8'd38, OP_DIVW = 8'd39, OP_DIVUW = 8'd40;
    localparam op_code_t OP_REMW = 8'd41, OP_REMUW = 8'd42;

    // Stores and branches
    localparam op_code_t OP_SB   = 8'd43, OP_SH = 8'd44, OP_SW = 8'd45, OP_SD = 8'd46;
    localparam op_code_t OP_BEQ  = 8'd47, OP_BNE = 8'd48, OP_BLT = 8'd49, OP_BGE = 8'd50;
    localparam op_code_t OP_BLTU = 8'd51, OP_BGEU = 8'd52;

    // Jumps, upper immediates, system
    localparam op_code_t OP_JAL  = 8'd53, OP_JALR = 8'd54, OP_LUI = 8'd55, OP_AUIPC = 8'd56;
    localparam op_code_t OP_ECALL = 8'd57, OP_EBREAK = 8'd58;

    // Loads
    localparam op_code_t OP_LB   = 8'd59, OP_LH = 8'd60, OP_LW = 8'd61, OP_LBU = 8'd62;
    localparam op_code_t OP_LHU  = 8'd63, OP_LWU = 8'd64, OP_LD = 8'd65;

    localparam op_code_t OP_UNKNOWN = 8'd255;

    // Immediate layout selected by the classifier
    typedef enum logic [3:0] {
        FMT_R,      // No immediate
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_I_SH6,  // 64-bit shifts
        FMT_I_SH5,  // 32-bit shifts
        FMT_NONE
    } instr_fmt_e;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
        shamt_t   shamt;
        op_code_t op;
    } decode_rec_t;

endpackage

`default_nettype wire

// ==== hw/op_classifier.sv ====
// Operation classifier mapping opcode and funct fields to operation code and format
`timescale 1ns/1ps
`default_nettype none

module op_classifier (
    input  rv_decode_pkg::instr_t     instruction,
    output rv_decode_pkg::op_code_t   op,
    output rv_decode_pkg::instr_fmt_e fmt
);

    rv_decode_pkg::opcode_t opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [5:0]             funct6;  // RV64 shift immediates use bit 25 for shamt
    logic [11:0]            funct12;

    assign opcode  = instruction[6:0];
    assign funct3  = instruction[14:12];
    assign funct7  = instruction[31:25];
    assign funct6  = instruction[31:26];
    assign funct12 = instruction[31:20];

    always_comb begin
        op  = rv_decode_pkg::OP_UNKNOWN;
        fmt = rv_decode_pkg::FMT_NONE;

        case (opcode)
            rv_decode_pkg::OPC_OP: begin
                fmt = rv_decode_pkg::FMT_R;
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000: op = rv_decode_pkg::OP_ADD;
                            3'b001: op = rv_decode_pkg::OP_SLL;
                            3'b010: op = rv_decode_pkg::OP_SLT;
                            3'b011: op = rv_decode_pkg::OP_SLTU;
                            3'b100: op = rv_decode_pkg::OP_XOR;
                            3'b101: op = rv_decode_pkg::OP_SRL;
                            3'b110: op = rv_decode_pkg::OP_OR;
                            3'b111: op = rv_decode_pkg::OP_AND;
                        endcase
                    end
                    7'b0000001: begin  // M extension
                        case (funct3)
                            3'b000: op = rv_decode_pkg::OP_MUL;
                            3'b001: op = rv_decode_pkg::OP_MULH;
                            3'b010: op = rv_decode_pkg::OP_MULHSU;
                            3'b011: op = rv_decode_pkg::OP_MULHU;
                            3'b100: op = rv_decode_pkg::OP_DIV;
                            3'b101: op = rv_decode_pkg::OP_DIVU;
                            3'b110: op = rv_decode_pkg::OP_REM;
                            3'b111: op = rv_decode_pkg::OP_REMU;
                        endcase
                    end
                    7'b0100000: begin
                        if (funct3 == 3'b000) op = rv_decode_pkg::OP_SUB;
                        else if (funct3 == 3'b101) op = rv_decode_pkg::OP_SRA;
                    end
                    default: op = rv_decode_pkg::OP_UNKNOWN;
                endcase
            end

            rv_decode_pkg::OPC_OP_IMM: begin
                fmt = rv_decode_pkg::FMT_I;
                case (funct3)
                    3'b000: op = rv_decode_pkg::OP_ADDI;
                    3'b010: op = rv_decode_pkg::OP_SLTI;
                    3'b011: op = rv_decode_pkg::OP_SLTIU;
                    3'b100: op = rv_decode_pkg::OP_XORI;
                    3'b110: op = rv_decode_pkg::OP_ORI;
                    3'b111: op = rv_decode_pkg::OP_ANDI;
                    3'b001: begin
                        fmt = rv_decode_pkg::FMT_I_SH6;
                        if (funct6 == 6'b000000) op = rv_decode_pkg::OP_SLLI;
                    end
                    3'b101: begin
                        fmt = rv_decode_pkg::FMT_I_SH6;
                        if (funct6 == 6'b000000) op = rv_decode_pkg::OP_SRLI;
                        else if (funct6 == 6'b010000) op = rv_decode_pkg::OP_SRAI;
                    end
                endcase
            end

            rv_decode_pkg::OPC_OP_32: begin
                fmt = rv_decode_pkg::FMT_R;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = rv_decode_pkg::OP_ADDW;
                    {7'b0100000, 3'b000}: op = rv_decode_pkg::OP_SUBW;
                    {7'b0000000, 3'b001}: op = rv_decode_pkg::OP_SLLW;
                    {7'b0000000, 3'b101}: op = rv_decode_pkg::OP_SRLW;
                    {7'b0100000, 3'b101}: op = rv_decode_pkg::OP_SRAW;
                    {7'b0000001, 3'b000}: op = rv_decode_pkg::OP_MULW;
                    {7'b0000001, 3'b100}: op = rv_decode_pkg::OP_DIVW;
                    {7'b0000001, 3'b101}: op = rv_decode_pkg::OP_DIVUW;
                    {7'b0000001, 3'b110}: op = rv_decode_pkg::OP_REMW;
                    {7'b0000001, 3'b111}: op = rv_decode_pkg::OP_REMUW;
                    default:              op = rv_decode_pkg::OP_UNKNOWN;
                endcase
            end

            rv_decode_pkg::OPC_OP_IMM_32: begin
                fmt = rv_decode_pkg::FMT_I;
                if (funct3 == 3'b000) begin
                    op = rv_decode_pkg::OP_ADDIW;
                end else if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    fmt = rv_decode_pkg::FMT_I_SH5;
                    if (funct7 == 7'b0000000) begin
                        op = (funct3 == 3'b001) ? rv_decode_pkg::OP_SLLIW : rv_decode_pkg::OP_SRLIW;
                    end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                        op = rv_decode_pkg::OP_SRAIW;
                    end
                end
            end

            rv_decode_pkg::OPC_STORE: begin
                fmt = rv_decode_pkg::FMT_S;
                case (funct3)
                    3'b000:  op = rv_decode_pkg::OP_SB;
                    3'b001:  op = rv_decode_pkg::OP_SH;
                    3'b010:  op = rv_decode_pkg::OP_SW;
                    3'b011:  op = rv_decode_pkg::OP_SD;
                    default: op = rv_decode_pkg::OP_UNKNOWN;
                endcase
            end

            rv_decode_pkg::OPC_BRANCH: begin
                fmt = rv_decode_pkg::FMT_B;
                case (funct3)
                    3'b000:  op = rv_decode_pkg::OP_BEQ;
                    3'b001:  op = rv_decode_pkg::OP_BNE;
                    3'b100:  op = rv_decode_pkg::OP_BLT;
                    3'b101:  op = rv_decode_pkg::OP_BGE;
                    3'b110:  op = rv_decode_pkg::OP_BLTU;
                    3'b111:  op = rv_decode_pkg::OP_BGEU;
                    default: op = rv_decode_pkg::OP_UNKNOWN;
                endcase
            end

            rv_decode_pkg::OPC_JAL: begin
                fmt = rv_decode_pkg::FMT_J;
                op  = rv_decode_pkg::OP_JAL;
            end

            rv_decode_pkg::OPC_JALR: begin
                fmt = rv_decode_pkg::FMT_I;
                if (funct3 == 3'b000) op = rv_decode_pkg::OP_JALR;
            end

            rv_decode_pkg::OPC_LUI: begin
                fmt = rv_decode_pkg::FMT_U;
                op  = rv_decode_pkg::OP_LUI;
            end

            rv_decode_pkg::OPC_AUIPC: begin
                fmt = rv_decode_pkg::FMT_U;
                op  = rv_decode_pkg::OP_AUIPC;
            end

            rv_decode_pkg::OPC_SYSTEM: begin
                fmt = rv_decode_pkg::FMT_I;
                if (funct3 == 3'b000 && funct12 == 12'h000) op = rv_decode_pkg::OP_ECALL;
                else if (funct3 == 3'b000 && funct12 == 12'h001) op = rv_decode_pkg::OP_EBREAK;
            end

            rv_decode_pkg::OPC_LOAD: begin
                fmt = rv_decode_pkg::FMT_I;
                case (funct3)
                    3'b000:  op = rv_decode_pkg::OP_LB;
                    3'b001:  op = rv_decode_pkg::OP_LH;
                    3'b010:  op = rv_decode_pkg::OP_LW;
                    3'b011:  op = rv_decode_pkg::OP_LD;
                    3'b100:  op = rv_decode_pkg::OP_LBU;
                    3'b101:  op = rv_decode_pkg::OP_LHU;
                    3'b110:  op = rv_decode_pkg::OP_LWU;
                    default: op = rv_decode_pkg::OP_UNKNOWN;
                endcase
            end

            default: op = rv_decode_pkg::OP_UNKNOWN;
        endcase

        // Unknown encodings never carry an immediate
        if (op == rv_decode_pkg::OP_UNKNOWN) fmt = rv_decode_pkg::FMT_NONE;
    end

endmodule

`default_nettype wire

// ==== hw/imm_generator.sv ====
// Immediate and shift-amount generator driven by the instruction format
`timescale 1ns/1ps
`default_nettype none

module imm_generator (
    input  rv_decode_pkg::instr_t     instruction,
    input  rv_decode_pkg::instr_fmt_e fmt,
    output rv_decode_pkg::imm_t       imm,
    output rv_decode_pkg::shamt_t     shamt
);

    rv_decode_pkg::imm_t imm_i;
    rv_decode_pkg::imm_t imm_s;
    rv_decode_pkg::imm_t imm_b;
    rv_decode_pkg::imm_t imm_u;
    rv_decode_pkg::imm_t imm_j;
    logic                sign;

    assign sign = instruction[31];  // All formats sign-extend from bit 31

    assign imm_i = {{52{sign}}, instruction[31:20]};
    assign imm_s = {{52{sign}}, instruction[31:25], instruction[11:7]};

    // Branch offset, bit 0 always zero
    assign imm_b = {{51{sign}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};

    assign imm_u = {{32{sign}}, instruction[31:12], 12'b0};

    assign imm_j = {{43{sign}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        imm   = '0;
        shamt = '0;
        case (fmt)
            rv_decode_pkg::FMT_I: imm = imm_i;
            rv_decode_pkg::FMT_S: imm = imm_s;
            rv_decode_pkg::FMT_B: imm = imm_b;
            rv_decode_pkg::FMT_U: imm = imm_u;
            rv_decode_pkg::FMT_J: imm = imm_j;
            rv_decode_pkg::FMT_I_SH6: begin
                imm   = imm_i;
                shamt = instruction[25:20];
            end
            rv_decode_pkg::FMT_I_SH5: begin
                imm   = imm_i;
                shamt = {1'b0, instruction[24:20]};  // Word shifts only reach 31
            end
            default: begin
                // R-type and unknown leave both at zero
                imm   = '0;
                shamt = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage_reg.sv ====
// Output register stage for the decode record and completion flag, with checks
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       decode_enable,
    input  rv_decode_pkg::instr_t      instruction,
    input  rv_decode_pkg::op_code_t    op,
    input  rv_decode_pkg::imm_t        imm,
    input  rv_decode_pkg::shamt_t      shamt,
    output rv_decode_pkg::decode_rec_t result,
    output logic                       decode_complete
);

    rv_decode_pkg::decode_rec_t rec_next;

    // Register fields are raw bits regardless of format
    always_comb begin
        rec_next.opcode = instruction[6:0];
        rec_next.rd     = instruction[11:7];
        rec_next.rs1    = instruction[19:15];
        rec_next.rs2    = instruction[24:20];
        rec_next.imm    = imm;
        rec_next.shamt  = shamt;
        rec_next.op     = op;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result          <= '0;
            decode_complete <= 1'b0;
        end else begin
            result          <= decode_enable ? rec_next : '0;  // Idle cycles load zeros
            decode_complete <= decode_enable;
        end
    end

    a_complete_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(decode_complete))
        else $error("decode_complete is unknown");

    a_idle_no_complete: assert property (@(posedge clk) disable iff (!rst_n)
        !decode_enable |=> !decode_complete)
        else $error("decode_complete high after an idle cycle");

    // Classifier and immediate generator must agree on unknown encodings
    a_unknown_no_imm: assert property (@(posedge clk) disable iff (!rst_n)
        (decode_complete && result.op == rv_decode_pkg::OP_UNKNOWN)
            |-> (result.imm == '0 && result.shamt == '0))
        else $error("unknown op carries an immediate or shift amount");

endmodule

`default_nettype wire

// ==== hw/rv_decoder_top.sv ====
// Registered RV64IM decoder top with classifier, immediate generator and stage register
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv_decode_pkg::instr_t      instruction,
    input  logic                       decode_enable,
    output rv_decode_pkg::decode_rec_t result,
    output logic                       decode_complete
);

    rv_decode_pkg::op_code_t   op;
    rv_decode_pkg::instr_fmt_e fmt;
    rv_decode_pkg::imm_t       imm;
    rv_decode_pkg::shamt_t     shamt;

    op_classifier u_op_classifier (
        .instruction (instruction),
        .op          (op),
        .fmt         (fmt)
    );

    imm_generator u_imm_generator (
        .instruction (instruction),
        .fmt         (fmt),
        .imm         (imm),
        .shamt       (shamt)
    );

    // One cycle of latency lives here
    decode_stage_reg u_decode_stage_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .decode_enable   (decode_enable),
        .instruction     (instruction),
        .op              (op),
        .imm             (imm),
        .shamt           (shamt),
        .result          (result),
        .decode_complete (decode_complete)
    );

endmodule

`default_nettype wire

// ==== tests/decode_checker.sv ====
// Decode checker comparing DUT records and completion flags with expected values
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
    input  logic                       clk,
    input  logic                       check_en,
    input  logic [127:0]               case_name,
    input  logic                       exp_complete,
    input  rv_decode_pkg::decode_rec_t exp_rec,
    input  rv_decode_pkg::decode_rec_t result,
    input  logic                       decode_complete,
    output int                         error_count,
    output int                         complete_count
);

    int errors = 0;
    int completes = 0;

    assign error_count    = errors;
    assign complete_count = completes;

    task automatic check_field(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error: case %0s %s expected %h actual %h",
                     case_name, field, expected, actual);
            errors++;
        end
    endtask

    // Mid-cycle sampling, outputs settled since the rising edge
    always @(negedge clk) begin
        if (check_en) begin
            if (decode_complete === 1'b1) begin
                completes++;
            end
            if (decode_complete !== exp_complete) begin
                if (exp_complete) begin
                    $display("decode_complete did not arrive for case %0s", case_name);
                end else begin
                    $display("decode_complete was high with no case in flight");
                end
                errors++;
            end
            // Idle cycles expect an all-zero record
            check_field("opcode", 64'(exp_rec.opcode), 64'(result.opcode));
            check_field("rd", 64'(exp_rec.rd), 64'(result.rd));
            check_field("rs1", 64'(exp_rec.rs1), 64'(result.rs1));
            check_field("rs2", 64'(exp_rec.rs2), 64'(result.rs2));
            check_field("imm", 64'(exp_rec.imm), 64'(result.imm));
            check_field("shamt", 64'(exp_rec.shamt), 64'(result.shamt));
            check_field("op", 64'(exp_rec.op), 64'(result.op));
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_rv_decoder.sv ====
// Testbench top with clock, reset, case file reading, stimulus and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder;

    localparam int MAX_CASES = 64;

    logic                       clk;
    logic                       rst_n;
    rv_decode_pkg::instr_t      instruction;
    logic                       decode_enable;
    rv_decode_pkg::decode_rec_t result;
    logic                       decode_complete;

    logic                       check_en;
    logic [127:0]               exp_name;
    logic                       exp_complete;
    rv_decode_pkg::decode_rec_t exp_rec;
    logic [127:0]               pend_name;  // Case captured at the next edge
    logic                       pend_complete;
    rv_decode_pkg::decode_rec_t pend_rec;
    int                         error_count;
    int                         complete_count;

    logic [127:0]             case_name [MAX_CASES];
    rv_decode_pkg::instr_t    case_instr [MAX_CASES];
    logic                     case_en [MAX_CASES];
    rv_decode_pkg::op_code_t  case_op [MAX_CASES];
    rv_decode_pkg::imm_t      case_imm [MAX_CASES];
    rv_decode_pkg::shamt_t    case_shamt [MAX_CASES];
    int n_cases = 0;
    int n_enabled = 0;
    int seed = 32'h684b;
    int cycle_count = 0;
    int cycle_limit = 1000;
    int total_errors;

    rv_decoder_top u_rv_decoder_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .instruction     (instruction),
        .decode_enable   (decode_enable),
        .result          (result),
        .decode_complete (decode_complete)
    );

    decode_checker u_decode_checker (
        .clk             (clk),
        .check_en        (check_en),
        .case_name       (exp_name),
        .exp_complete    (exp_complete),
        .exp_rec         (exp_rec),
        .result          (result),
        .decode_complete (decode_complete),
        .error_count     (error_count),
        .complete_count  (complete_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic read_cases();
        int           fd;
        int           cnt;
        string        line;
        logic [127:0] nm;
        logic [31:0]  ins;
        int           en_i;
        int           op_i;
        int           sh_i;
        logic [63:0]  im;
        fd = $fopen("tests/decode_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/decode_cases.txt");
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.getc(0) != "#") begin  // Skip comment lines
                    cnt = $sscanf(line, "%s %h %d %d %h %d", nm, ins, en_i, op_i, im, sh_i);
                    if (cnt == 6) begin
                        case_name[n_cases]  = nm;
                        case_instr[n_cases] = ins;
                        case_en[n_cases]    = (en_i != 0);
                        case_op[n_cases]    = op_i[7:0];
                        case_imm[n_cases]   = im;
                        case_shamt[n_cases] = sh_i[5:0];
                        if (en_i != 0) n_enabled++;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One cycle of stimulus, expected record delayed by the fixed latency
    task automatic drive_cycle(input rv_decode_pkg::instr_t ins, input logic en,
                               input logic [127:0] nm, input rv_decode_pkg::op_code_t op,
                               input rv_decode_pkg::imm_t imm,
                               input rv_decode_pkg::shamt_t sh);
        @(posedge clk);
        #2;
        exp_name      = pend_name;
        exp_complete  = pend_complete;
        exp_rec       = pend_rec;
        pend_name     = nm;
        pend_complete = en;
        // Register fields are the raw bits for every format
        pend_rec      = en ? {ins[6:0], ins[11:7], ins[19:15], ins[24:20], imm, sh, op} : '0;
        instruction   = en ? ins : $random(seed);
        decode_enable = en;
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b1;
        instruction   = '0;
        decode_enable = 1'b0;
        check_en      = 1'b0;
        exp_name      = '0;
        exp_complete  = 1'b0;
        exp_rec       = '0;
        pend_name     = '0;
        pend_complete = 1'b0;
        pend_rec      = '0;
        read_cases();
        cycle_limit = 2 * n_cases + 20;
        #1;
        rst_n    = 1'b0;
        check_en = 1'b1;  // Reset values are checked as idle cycles
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        if (n_cases == 0) begin
            $display("no cases were read, nothing to run");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            for (int i = 0; i < n_cases; i++) begin
                drive_cycle(case_instr[i], case_en[i], case_name[i],
                            case_op[i], case_imm[i], case_shamt[i]);
            end
            drive_cycle('0, 1'b0, '0, '0, '0, '0);  // Drain the last case
            drive_cycle('0, 1'b0, '0, '0, '0, '0);
            @(negedge clk);
            #1;
            total_errors = error_count;
            if (complete_count != n_enabled) begin
                $display("saw %0d completions for %0d enabled cases", complete_count, n_enabled);
                total_errors++;
            end
            $display("cases %0d, completions %0d, errors %0d",
                     n_cases, complete_count, total_errors);
            if (total_errors == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/decode_cases.txt ====
# name instruction(hex) enable op(dec) imm(hex, 64-bit) shamt(dec)
# Lines with enable 0 are idle cycles, their other columns are ignored
idle_start 00000000 0 0 0000000000000000 0
add 003100B3 1 0 0000000000000000 0
sub 407302B3 1 1 0000000000000000 0
xor 00C5C533 1 2 0000000000000000 0
or 003160B3 1 3 0000000000000000 0
sll 003110B3 1 5 0000000000000000 0
srl 003150B3 1 6 0000000000000000 0
sra 41DF5FB3 1 7 0000000000000000 0
mul 023100B3 1 10 0000000000000000 0
mulhu 0262B233 1 13 0000000000000000 0
divu 02A4D433 1 15 0000000000000000 0
remu 023170B3 1 17 0000000000000000 0
idle_mid 00000000 0 0 0000000000000000 0
addw 003100BB 1 33 0000000000000000 0
sraw 403150BB 1 37 0000000000000000 0
divuw 023150BB 1 40 0000000000000000 0
remuw 023170BB 1 42 0000000000000000 0
addi_neg FFB10093 1 18 FFFFFFFFFFFFFFFB 0
slli_63 03F11093 1 22 000000000000003F 63
srai_33 42115093 1 24 0000000000000421 33
sraiw_7 4071509B 1 32 0000000000000407 7
ld_neg FF813283 1 65 FFFFFFFFFFFFFFF8 0
jalr 010280E7 1 54 0000000000000010 0
idle_a 00000000 0 0 0000000000000000 0
idle_b 00000000 0 0 0000000000000000 0
sd_neg FE313823 1 46 FFFFFFFFFFFFFFF0 0
beq_neg FE208CE3 1 47 FFFFFFFFFFFFFFF8 0
bltu_pos 0662E263 1 51 0000000000000064 0
lui_pos 123452B7 1 55 0000000012345000 0
lui_neg FFFFF0B7 1 55 FFFFFFFFFFFFF000 0
auipc 80000517 1 56 FFFFFFFF80000000 0
jal_pos 001000EF 1 53 0000000000000800 0
jal_neg FFDFF06F 1 53 FFFFFFFFFFFFFFFC 0
ecall 00000073 1 57 0000000000000000 0
ebreak 00100073 1 58 0000000000000001 0
bad_funct7 203100B3 1 255 0000000000000000 0
opcode_zero 12345680 1 255 0000000000000000 0
sys_bad 00200073 1 255 0000000000000000 0
idle_end 00000000 0 0 0000000000000000 0

// ==== sim.f ====
hw/rv_decode_pkg.sv
hw/op_classifier.sv
hw/imm_generator.sv
hw/decode_stage_reg.sv
hw/rv_decoder_top.sv
tests/decode_checker.sv
tests/tb_rv_decoder.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module tb_rv_decoder -Mdir obj_dir

out=$(./obj_dir/Vtb_rv_decoder)
echo "$out"

# Exit status follows the pass message
echo "$out" | grep -q "TEST RESULT: PASS"
